/* Makefile */
# Verilator build of the histogram testbench

TOOL      = verilator
FLAGS     = --binary --timing -Wno-fatal
TOP       = tb_hist_top
FILELIST  = project.f
BUILD_DIR = obj_dir
LOG       = sim.log
PASS_MSG  = Verification passed

.PHONY: all compile run clean

all: run

compile:
	$(TOOL) $(FLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(BUILD_DIR)

# the log decides pass or fail, not the exit status of the binary
run: compile
	./$(BUILD_DIR)/V$(TOP) | tee $(LOG)
	grep -qx "$(PASS_MSG)" $(LOG)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

/* project.f */
source/hist_types_pkg.sv
source/hist_bus_pkg.sv
source/hist_ctrl_fsm.sv
source/hist_event_counter.sv
source/hist_bank_ram.sv
source/hist_wb_readout.sv
source/hist_top.sv
sim/tb_clock_gen.sv
sim/tb_hist_top.sv

/* sim/tb_clock_gen.sv */
`default_nettype none

module tb_clock_gen (
    output logic clk,
    output logic res
);
    timeunit 1ns;
    timeprecision 100ps;

    // 40 ns period
    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    // reset held for 8 cycles, released on a falling edge
    initial begin
        res = 1'b0;
        repeat (8) @(posedge clk);
        @(negedge clk);
        res = 1'b1;
    end

endmodule

`default_nettype wire

/* sim/tb_hist_top.sv */
`default_nettype none

module tb_hist_top;
    timeunit 1ns;
    timeprecision 100ps;

    localparam int N_BINS       = 8;
    localparam int PIXELS       = 4;
    localparam int SAMPLES      = 3;
    localparam int ACQS         = 2;
    localparam int BANK_WORDS   = N_BINS * PIXELS;
    localparam int EV_PER_FRAME = SAMPLES * PIXELS * ACQS;
    localparam int N_FRAMES     = 3;
    // clear sweep alone is 32 cycles
    localparam int EVENT_WAIT   = 100;
    localparam int POLL_MAX     = 40;

    typedef enum logic [2:0] {
        OP_EVENT, OP_RD_STATUS, OP_RD_BIN, OP_WR_STATUS, OP_WAIT_FRAME
    } op_t;

    // arg is the bin for events, the word address or frame number otherwise
    typedef struct packed {
        op_t         op;
        logic [7:0]  arg;
        logic [31:0] exp;
    } row_t;

    logic                   clk;
    logic                   res;
    logic                   event_valid;
    logic [2:0]             event_bin;
    logic                   event_ready;
    logic                   wb_cyc;
    logic                   wb_stb;
    logic                   wb_we;
    hist_bus_pkg::wb_adr_t  wb_adr;
    hist_bus_pkg::wb_word_t wb_dat_w;
    hist_bus_pkg::wb_word_t wb_dat_r;
    logic                   wb_ack;

    row_t        rows[$];
    string       names[$];
    int          model_hist [BANK_WORDS];
    logic [31:0] lcg_state;
    int          value_errors;
    int          proto_errors;
    int          cycles;
    int          cycle_limit = 0;

    tb_clock_gen u_clk (
        .clk (clk),
        .res (res)
    );

    hist_top #(
        .N_BINS  (N_BINS),
        .PIXELS  (PIXELS),
        .SAMPLES (SAMPLES),
        .ACQS    (ACQS)
    ) u_dut (
        .clk         (clk),
        .res         (res),
        .event_valid (event_valid),
        .event_bin   (event_bin),
        .event_ready (event_ready),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .wb_dat_r    (wb_dat_r),
        .wb_ack      (wb_ack)
    );

    function automatic logic [31:0] lcg_next(input logic [31:0] s);
        return s * 32'd1664525 + 32'd1013904223;
    endfunction

    function automatic hist_bus_pkg::hist_status_t make_status(
        input int fc, input logic ovr, input logic rb, input logic rdy);
        hist_bus_pkg::hist_status_t s;
        s             = '0;
        s.frame_count = 16'(fc);
        s.overrun     = ovr;
        s.ready_bank  = rb;
        s.ready       = rdy;
        return s;
    endfunction

    task automatic add_row(input op_t op, input int arg, input logic [31:0] exp,
                           input string name);
        row_t r;
        r.op  = op;
        r.arg = 8'(arg);
        r.exp = exp;
        rows.push_back(r);
        names.push_back(name);
    endtask

    // events in sample, pixel, acquisition order with the model histogram alongside
    task automatic add_frame(input int frame);
        int pix;
        int bin;
        foreach (model_hist[i]) begin
            model_hist[i] = 0;
        end
        for (int e = 0; e < EV_PER_FRAME; e++) begin
            pix       = (e / SAMPLES) % PIXELS;
            lcg_state = lcg_next(lcg_state);
            bin       = int'(lcg_state[31:29]);
            // same bin back to back hits the forwarding path
            if (frame == 1 && e < SAMPLES) bin = 5;
            // pixel 1 of acquisition 1
            if (frame == 2 && e >= 15 && e < 18) bin = 2;
            // last pixel up to frame_last
            if (frame == 3 && e >= 21) bin = 7;
            model_hist[pix * N_BINS + bin]++;
            add_row(OP_EVENT, bin, '0, $sformatf("f%0d_ev%0d", frame, e));
        end
    endtask

    // bin k at word address k + 1
    task automatic add_bin_dump(input int frame);
        for (int k = 0; k < BANK_WORDS; k++) begin
            add_row(OP_RD_BIN, k + 1, 32'(model_hist[k]), $sformatf("f%0d_bin%0d", frame, k));
        end
    endtask

    task automatic build_table();
        int n_bus;
        lcg_state = 32'h1a24dec9;
        add_row(OP_RD_STATUS, 0, make_status(0, 1'b0, 1'b0, 1'b0), "reset_status");
        add_frame(1);
        add_row(OP_WAIT_FRAME, 1, '0, "f1_wait");
        add_row(OP_RD_STATUS, 0, make_status(1, 1'b0, 1'b0, 1'b1), "f1_status");
        add_bin_dump(1);
        add_row(OP_WR_STATUS, 0, '0, "f1_release");
        add_row(OP_RD_STATUS, 0, make_status(1, 1'b0, 1'b0, 1'b0), "f1_released");
        add_frame(2);
        add_row(OP_WAIT_FRAME, 2, '0, "f2_wait");
        add_row(OP_RD_STATUS, 0, make_status(2, 1'b0, 1'b1, 1'b1), "f2_status");
        add_bin_dump(2);
        // no release before frame 3
        add_frame(3);
        add_row(OP_WAIT_FRAME, 3, '0, "f3_wait");
        add_row(OP_RD_STATUS, 0, make_status(3, 1'b1, 1'b0, 1'b1), "f3_overrun");
        add_bin_dump(3);
        add_row(OP_WR_STATUS, 0, '0, "f3_release");
        add_row(OP_RD_STATUS, 0, make_status(3, 1'b0, 1'b0, 1'b0), "f3_released");
        n_bus = 0;
        foreach (rows[i]) begin
            if (rows[i].op != OP_EVENT) n_bus++;
        end
        cycle_limit = 2 * (8 + N_FRAMES * (EV_PER_FRAME + BANK_WORDS + 10) + 4 * n_bus);
    endtask

    task automatic check_count(input string name, input hist_types_pkg::bin_count_t exp,
                               input hist_types_pkg::bin_count_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %0d actual %0d", name, exp, act);
            value_errors++;
        end
    endtask

    task automatic check_status(input string name, input hist_bus_pkg::hist_status_t exp,
                                input hist_bus_pkg::hist_status_t act);
        if (act !== exp) begin
            $display("FAIL %s: expected %h actual %h", name, exp, act);
            value_errors++;
        end
    endtask

    // starts and ends on a falling edge so valid stays up between events
    task automatic do_event(input string name, input logic [2:0] bin);
        int waited;
        waited      = 0;
        event_valid = 1'b1;
        event_bin   = bin;
        while (!event_ready && waited < EVENT_WAIT) begin
            @(negedge clk);
            waited++;
        end
        if (!event_ready) begin
            $display("%s: event_ready stuck low for %0d cycles", name, EVENT_WAIT);
            proto_errors++;
        end else begin
            @(posedge clk);
            @(negedge clk);
        end
        event_valid = 1'b0;
    endtask

    // classic cycle with ack one cycle after stb
    task automatic bus_cycle(input string name, input logic we,
                             input hist_bus_pkg::wb_adr_t adr,
                             input hist_bus_pkg::wb_word_t wdat,
                             output hist_bus_pkg::wb_word_t rdat, output logic ok);
        int waited;
        waited   = 0;
        wb_cyc   = 1'b1;
        wb_stb   = 1'b1;
        wb_we    = we;
        wb_adr   = adr;
        wb_dat_w = wdat;
        @(negedge clk);
        while (!wb_ack && waited < 4) begin
            @(negedge clk);
            waited++;
        end
        ok   = wb_ack;
        rdat = wb_dat_r;
        if (!wb_ack) begin
            $display("%s: no ack on the bus for address %0d", name, adr);
            proto_errors++;
        end else if (waited != 0) begin
            $display("%s: ack came %0d cycles late", name, waited);
            proto_errors++;
        end
        wb_cyc = 1'b0;
        wb_stb = 1'b0;
        wb_we  = 1'b0;
        @(negedge clk);
    endtask

    // poll frame_count since ready alone misses an overrun frame
    task automatic wait_frame(input string name, input int frame);
        hist_bus_pkg::rd_word_u w;
        hist_bus_pkg::wb_word_t word;
        logic                   ok;
        int                     polls;
        polls = 0;
        w     = '0;
        while (int'(w.status.frame_count) != frame && polls < POLL_MAX) begin
            bus_cycle(name, 1'b0, hist_bus_pkg::STATUS_ADDR, '0, word, ok);
            w = word;
            polls++;
        end
        if (int'(w.status.frame_count) != frame) begin
            $display("%s: frame %0d never completed", name, frame);
            proto_errors++;
        end
    endtask

    // event port held off through the first sweep and through drain, swap and sweep
    // after every frame
    initial begin : ready_monitor
        int quiet;
        int accepted;
        accepted = 0;
        wait (res === 1'b1);
        quiet = BANK_WORDS;
        forever begin
            @(posedge clk);
            if (event_valid && event_ready) begin
                accepted++;
                if (accepted % EV_PER_FRAME == 0) begin
                    quiet = BANK_WORDS + 3;
                end
            end
            @(negedge clk);
            if (quiet > 0) begin
                if (event_ready) begin
                    $display("event_ready high while the FSM should drain or clear");
                    proto_errors++;
                end
                quiet--;
            end
        end
    end

    initial begin : watchdog
        cycles = 0;
        wait (cycle_limit > 0);
        while (cycles < cycle_limit) begin
            @(posedge clk);
            cycles++;
        end
        $display("timeout: run stopped after %0d cycles", cycles);
        $display("value errors %0d, protocol errors %0d", value_errors, proto_errors);
        $display("Verification failed");
        $finish;
    end

    initial begin : main
        hist_bus_pkg::rd_word_u w;
        hist_bus_pkg::wb_word_t word;
        logic                   ok;
        event_valid  = 1'b0;
        event_bin    = '0;
        wb_cyc       = 1'b0;
        wb_stb       = 1'b0;
        wb_we        = 1'b0;
        wb_adr       = '0;
        wb_dat_w     = '0;
        value_errors = 0;
        proto_errors = 0;
        build_table();
        wait (res === 1'b1);
        @(negedge clk);
        foreach (rows[i]) begin
            case (rows[i].op)
                OP_EVENT: begin
                    do_event(names[i], rows[i].arg[2:0]);
                end
                OP_RD_STATUS: begin
                    bus_cycle(names[i], 1'b0, rows[i].arg, '0, word, ok);
                    w = word;
                    if (ok) check_status(names[i], rows[i].exp, w.status);
                end
                OP_RD_BIN: begin
                    bus_cycle(names[i], 1'b0, rows[i].arg, '0, word, ok);
                    w = word;
                    if (ok) check_count(names[i], rows[i].exp[15:0], w.bin.count);
                end
                OP_WR_STATUS: begin
                    // any data releases the frame
                    bus_cycle(names[i], 1'b1, rows[i].arg, 32'h1, word, ok);
                end
                default: begin
                    wait_frame(names[i], int'(rows[i].arg));
                end
            endcase
        end
        $display("value errors %0d, protocol errors %0d", value_errors, proto_errors);
        if (value_errors == 0 && proto_errors == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

/* source/hist_bank_ram.sv */
`default_nettype none

module hist_bank_ram #(
    parameter int N_BINS = 8,
    parameter int PIXELS = 4
) (
    input  logic                               clk,
    input  logic                               res,
    input  logic                               accept,
    input  logic [$clog2(N_BINS)-1:0]          event_bin,
    input  logic [$clog2(PIXELS)-1:0]          pixel_idx,
    input  hist_types_pkg::bank_sel_t          active_bank,
    input  logic                               clear_busy,
    input  logic [$clog2(PIXELS*N_BINS)-1:0]   clear_addr,
    input  logic                               rd_en,
    input  logic [$clog2(PIXELS*N_BINS)-1:0]   rd_addr,
    output hist_types_pkg::bin_count_t         rd_count
);

    localparam int HIST_AW = $clog2(PIXELS * N_BINS);
    // bank select is the top address bit
    localparam int MEM_AW  = HIST_AW + 1;

    hist_types_pkg::bin_count_t mem [2**MEM_AW];

    logic [MEM_AW-1:0] ev_addr;
    // stage 1, count read
    logic                       s1_valid;
    logic [MEM_AW-1:0]          s1_addr;
    hist_types_pkg::bin_count_t s1_rd;
    hist_types_pkg::bin_count_t s1_base;
    // stage 2, incremented count waiting for write
    logic                       s2_valid;
    logic [MEM_AW-1:0]          s2_addr;
    hist_types_pkg::bin_count_t s2_count;

    // pixel * N_BINS + bin, in the accumulating bank
    assign ev_addr = {active_bank, HIST_AW'(pixel_idx * N_BINS + event_bin)};

    // previous event to the same bin not written yet
    assign s1_base = (s2_valid && (s2_addr == s1_addr)) ? s2_count : s1_rd;

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            s1_valid <= 1'b0;
            s2_valid <= 1'b0;
        end else begin
            s1_valid <= accept;
            s2_valid <= s1_valid;
        end
    end

    always_ff @(posedge clk) begin
        s1_addr <= ev_addr;
        // write-through, stage 2 lands on this same edge
        if (s2_valid && (s2_addr == ev_addr)) begin
            s1_rd <= s2_count;
        end else begin
            s1_rd <= mem[ev_addr];
        end
        s2_addr  <= s1_addr;
        s2_count <= s1_base + hist_types_pkg::COUNT_INC;
    end

    // single write port, increments or clear zeros
    always_ff @(posedge clk) begin
        if (s2_valid) begin
            mem[s2_addr] <= s2_count;
        end else if (clear_busy) begin
            mem[{active_bank, clear_addr}] <= '0;
        end
    end

    // readout only ever sees the idle bank
    always_ff @(posedge clk) begin
        if (rd_en) begin
            rd_count <= mem[{~active_bank, rd_addr}];
        end
    end

endmodule

`default_nettype wire

/* source/hist_bus_pkg.sv */
`default_nettype none

package hist_bus_pkg;

    // wishbone data and word address
    localparam int WB_ADR_W = 8;
    typedef logic [31:0] wb_word_t;
    typedef logic [WB_ADR_W-1:0] wb_adr_t;

    // status word, msb first
    typedef struct packed {
        logic [15:0] frame_count;
        logic [12:0] reserved;
        logic        overrun;
        logic        ready_bank;
        logic        ready;
    } hist_status_t;

    // bin count zero-extended to a bus word
    typedef struct packed {
        logic [15:0]                pad;
        hist_types_pkg::bin_count_t count;
    } bin_word_t;

    // readout word, status view or bin view
    typedef union packed {
        hist_status_t status;
        bin_word_t    bin;
    } rd_word_u;

    // address map, bin k of the ready bank at BIN_BASE + k
    localparam wb_adr_t STATUS_ADDR = wb_adr_t'(0);
    localparam wb_adr_t BIN_BASE    = wb_adr_t'(1);

endpackage

`default_nettype wire

/* source/hist_ctrl_fsm.sv */
`default_nettype none

module hist_ctrl_fsm (
    input  logic                      clk,
    input  logic                      res,
    input  logic                      event_valid,
    input  logic                      frame_last,
    input  logic                      clear_done,
    output logic                      event_ready,
    output logic                      accum_en,
    output logic                      clear_start,
    output hist_types_pkg::bank_sel_t active_bank,
    output logic                      frame_done
);

    // frame states
    localparam logic [1:0] S_CLEAR = 2'd0;
    localparam logic [1:0] S_ACCUM = 2'd1;
    localparam logic [1:0] S_DRAIN = 2'd2;
    localparam logic [1:0] S_SWAP  = 2'd3;

    logic [1:0] state;
    // drain cycle counter, two cycles
    logic       drain_cnt;

    // events only taken while accumulating
    assign event_ready = (state == S_ACCUM);
    assign accum_en    = event_valid && event_ready;
    // one cycle in SWAP, so a single pulse
    assign frame_done  = (state == S_SWAP);

    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            state       <= S_CLEAR;
            drain_cnt   <= 1'b0;
            active_bank <= hist_types_pkg::BANK_0;
            // sweep bank 0 straight out of reset
            clear_start <= 1'b1;
        end else begin
            clear_start <= 1'b0;
            case (state)
                S_CLEAR: begin
                    if (clear_done) begin
                        state <= S_ACCUM;
                    end
                end
                S_ACCUM: begin
                    // last event of the frame accepted
                    if (accum_en && frame_last) begin
                        state     <= S_DRAIN;
                        drain_cnt <= 1'b0;
                    end
                end
                S_DRAIN: begin
                    // let the two in-flight writes land
                    if (drain_cnt) begin
                        state <= S_SWAP;
                    end else begin
                        drain_cnt <= 1'b1;
                    end
                end
                S_SWAP: begin
                    // old bank goes to readout, new one gets swept
                    active_bank <= ~active_bank;
                    clear_start <= 1'b1;
                    state       <= S_CLEAR;
                end
                default: begin
                    state <= S_CLEAR;
                end
            endcase
        end
    end

endmodule

`default_nettype wire

/* source/hist_event_counter.sv */
`default_nettype none

module hist_event_counter #(
    parameter int N_BINS  = 8,
    parameter int PIXELS  = 4,
    parameter int SAMPLES = 3,
    parameter int ACQS    = 2
) (
    input  logic                                 clk,
    input  logic                                 res,
    input  logic                                 accept,
    input  logic                                 clear_start,
    output logic [$clog2(PIXELS)-1:0]            pixel_idx,
    output logic                                 frame_last,
    output logic [$clog2(PIXELS*N_BINS)-1:0]     clear_addr,
    output logic                                 clear_busy,
    output logic                                 clear_done
);

    localparam int BANK_WORDS = PIXELS * N_BINS;
    localparam int HIST_AW    = $clog2(BANK_WORDS);
    localparam int PIX_W      = $clog2(PIXELS);
    // keep counters at least one bit wide
    localparam int SMP_W      = (SAMPLES > 1) ? $clog2(SAMPLES) : 1;
    localparam int ACQ_W      = (ACQS > 1) ? $clog2(ACQS) : 1;

    logic [SMP_W-1:0] sample_cnt;
    logic [PIX_W-1:0] pixel_cnt;
    logic [ACQ_W-1:0] acq_cnt;

    logic sample_last;
    logic pixel_last;
    logic acq_last;

    assign sample_last = (sample_cnt == SMP_W'(SAMPLES - 1));
    assign pixel_last  = (pixel_cnt == PIX_W'(PIXELS - 1));
    assign acq_last    = (acq_cnt == ACQ_W'(ACQS - 1));

    assign pixel_idx  = pixel_cnt;
    // final sample of final pixel of final acquisition
    assign frame_last = sample_last && pixel_last && acq_last;

    // samples, then pixels, then acquisitions
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            sample_cnt <= '0;
            pixel_cnt  <= '0;
            acq_cnt    <= '0;
        end else if (accept) begin
            if (!sample_last) begin
                sample_cnt <= sample_cnt + 1'b1;
            end else begin
                sample_cnt <= '0;
                if (!pixel_last) begin
                    pixel_cnt <= pixel_cnt + 1'b1;
                end else begin
                    pixel_cnt <= '0;
                    acq_cnt   <= acq_last ? '0 : acq_cnt + 1'b1;
                end
            end
        end
    end

    // clear sweep, one address per cycle across one bank
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            clear_addr <= '0;
            clear_busy <= 1'b0;
            clear_done <= 1'b0;
        end else begin
            clear_done <= 1'b0;
            if (clear_start) begin
                clear_addr <= '0;
                clear_busy <= 1'b1;
            end else if (clear_busy) begin
                if (clear_addr == HIST_AW'(BANK_WORDS - 1)) begin
                    clear_busy <= 1'b0;
                    clear_done <= 1'b1;
                end else begin
                    clear_addr <= clear_addr + 1'b1;
                end
            end
        end
    end

endmodule

`default_nettype wire

/* source/hist_top.sv */
`default_nettype none

module hist_top #(
    parameter int N_BINS  = 8,
    parameter int PIXELS  = 4,
    parameter int SAMPLES = 3,
    parameter int ACQS    = 2
) (
    input  logic                          clk,
    input  logic                          res,
    input  logic                          event_valid,
    input  logic [$clog2(N_BINS)-1:0]     event_bin,
    output logic                          event_ready,
    input  logic                          wb_cyc,
    input  logic                          wb_stb,
    input  logic                          wb_we,
    input  hist_bus_pkg::wb_adr_t         wb_adr,
    input  hist_bus_pkg::wb_word_t        wb_dat_w,
    output hist_bus_pkg::wb_word_t        wb_dat_r,
    output logic                          wb_ack
);

    localparam int HIST_AW = $clog2(PIXELS * N_BINS);

    logic                       accept;
    logic                       accum_en;
    logic                       clear_start;
    hist_types_pkg::bank_sel_t  active_bank;
    logic                       frame_done;
    logic [$clog2(PIXELS)-1:0]  pixel_idx;
    logic                       frame_last;
    logic [HIST_AW-1:0]         clear_addr;
    logic                       clear_busy;
    logic                       clear_done;
    logic                       rd_en;
    logic [HIST_AW-1:0]         rd_addr;
    hist_types_pkg::bin_count_t rd_count;

    // handshake on the event port
    assign accept = event_valid && event_ready;

    hist_ctrl_fsm u_ctrl (
        .clk         (clk),
        .res         (res),
        .event_valid (event_valid),
        .frame_last  (frame_last),
        .clear_done  (clear_done),
        .event_ready (event_ready),
        .accum_en    (accum_en),
        .clear_start (clear_start),
        .active_bank (active_bank),
        .frame_done  (frame_done)
    );

    hist_event_counter #(
        .N_BINS  (N_BINS),
        .PIXELS  (PIXELS),
        .SAMPLES (SAMPLES),
        .ACQS    (ACQS)
    ) u_counter (
        .clk         (clk),
        .res         (res),
        .accept      (accept),
        .clear_start (clear_start),
        .pixel_idx   (pixel_idx),
        .frame_last  (frame_last),
        .clear_addr  (clear_addr),
        .clear_busy  (clear_busy),
        .clear_done  (clear_done)
    );

    hist_bank_ram #(
        .N_BINS (N_BINS),
        .PIXELS (PIXELS)
    ) u_ram (
        .clk         (clk),
        .res         (res),
        .accept      (accum_en),
        .event_bin   (event_bin),
        .pixel_idx   (pixel_idx),
        .active_bank (active_bank),
        .clear_busy  (clear_busy),
        .clear_addr  (clear_addr),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr),
        .rd_count    (rd_count)
    );

    hist_wb_readout #(
        .N_BINS (N_BINS),
        .PIXELS (PIXELS)
    ) u_readout (
        .clk         (clk),
        .res         (res),
        .wb_cyc      (wb_cyc),
        .wb_stb      (wb_stb),
        .wb_we       (wb_we),
        .wb_adr      (wb_adr),
        .wb_dat_w    (wb_dat_w),
        .frame_done  (frame_done),
        .active_bank (active_bank),
        .rd_count    (rd_count),
        .wb_ack      (wb_ack),
        .wb_dat_r    (wb_dat_r),
        .rd_en       (rd_en),
        .rd_addr     (rd_addr)
    );

endmodule

`default_nettype wire

/* source/hist_types_pkg.sv */
`default_nettype none

package hist_types_pkg;

    // width of one histogram bin counter
    localparam int COUNT_W = 16;

    // one histogram count
    // no saturation logic, a frame never fills 16 bits
    typedef logic [COUNT_W-1:0] bin_count_t;

    // which of the two banks is accumulating
    typedef logic bank_sel_t;

    // bank select encodings
    localparam bank_sel_t BANK_0 = 1'b0;
    localparam bank_sel_t BANK_1 = 1'b1;

    // increment applied per accepted event
    localparam bin_count_t COUNT_INC = bin_count_t'(1);

endpackage

`default_nettype wire

/* source/hist_wb_readout.sv */
`default_nettype none

module hist_wb_readout #(
    parameter int N_BINS = 8,
    parameter int PIXELS = 4
) (
    input  logic                               clk,
    input  logic                               res,
    input  logic                               wb_cyc,
    input  logic                               wb_stb,
    input  logic                               wb_we,
    input  hist_bus_pkg::wb_adr_t              wb_adr,
    input  hist_bus_pkg::wb_word_t             wb_dat_w,
    input  logic                               frame_done,
    input  hist_types_pkg::bank_sel_t          active_bank,
    input  hist_types_pkg::bin_count_t         rd_count,
    output logic                               wb_ack,
    output hist_bus_pkg::wb_word_t             wb_dat_r,
    output logic                               rd_en,
    output logic [$clog2(PIXELS*N_BINS)-1:0]   rd_addr
);

    localparam int BANK_WORDS = PIXELS * N_BINS;
    localparam int HIST_AW    = $clog2(BANK_WORDS);

    hist_bus_pkg::hist_status_t status;
    hist_bus_pkg::rd_word_u     rsp;

    logic req;
    logic is_status;
    logic is_bin;
    logic release_req;
    // kind of the pending response
    logic rsp_status;
    logic rsp_bin;

    // new request, not yet acked
    assign req         = wb_cyc && wb_stb && !wb_ack;
    assign is_status   = (wb_adr == hist_bus_pkg::STATUS_ADDR);
    assign is_bin      = !is_status && (int'(wb_adr) <= BANK_WORDS);
    // any write to the status word frees the ready bank
    assign release_req = req && wb_we && is_status;

    assign rd_en   = req && !wb_we && is_bin;
    assign rd_addr = HIST_AW'(wb_adr - hist_bus_pkg::BIN_BASE);

    // one wait state, ack for a single clock
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            wb_ack     <= 1'b0;
            rsp_status <= 1'b0;
            rsp_bin    <= 1'b0;
        end else begin
            wb_ack     <= req;
            rsp_status <= req && !wb_we && is_status;
            rsp_bin    <= rd_en;
        end
    end

    // status register
    always_ff @(posedge clk or negedge res) begin
        if (!res) begin
            status <= '0;
        end else if (frame_done) begin
            status.frame_count <= status.frame_count + 1'b1;
            status.ready_bank  <= active_bank;
            status.ready       <= 1'b1;
            // previous frame never released
            status.overrun     <= !release_req && (status.ready || status.overrun);
        end else if (release_req) begin
            status.ready   <= 1'b0;
            status.overrun <= 1'b0;
        end
    end

    // response word, status view or zero-extended count
    always_comb begin
        rsp = '0;
        if (rsp_status) begin
            rsp.status = status;
        end else if (rsp_bin) begin
            rsp.bin.pad   = '0;
            rsp.bin.count = rd_count;
        end else if (wb_we) begin
            // write ack echoes the written word
            rsp = wb_dat_w;
        end
    end

    assign wb_dat_r = rsp;

endmodule

`default_nettype wire
